/* Makefile */
TOP := tb_fw_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f fw_core.f -o $(TOP)

run: compile
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" sim.log; then \
		echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* dv/fw_core_asserts.sv */
`timescale 1ns/100ps

module fw_core_asserts (
	input logic               clock,
	input logic               reset,
	input fw_core_pkg::word_t iaddr,
	input logic               ivalid,
	input logic               iready,
	input logic               dvalid,
	input fw_core_pkg::word_t daddr,
	input fw_core_pkg::word_t dwdata,
	input logic [3:0]         dwstb,
	input logic               dwrite,
	input logic               dready
);

	int fail_count = 0;  // Failed assertions so far

	ivalid_held: assert property (@(posedge clock) disable iff (reset)
		ivalid && !iready |=> ivalid && $stable(iaddr))
		else begin
			$error("ivalid dropped or iaddr changed before iready");
			fail_count++;
		end

	ivalid_drops: assert property (@(posedge clock) disable iff (reset)
		ivalid && iready |=> !ivalid)
		else begin
			$error("ivalid still high after the accepting edge");
			fail_count++;
		end

	dvalid_held: assert property (@(posedge clock) disable iff (reset)
		dvalid && !dready |=> dvalid && $stable(daddr) && $stable(dwdata) && $stable(dwrite))
		else begin
			$error("dvalid dropped or data bus request changed before dready");
			fail_count++;
		end

	dvalid_drops: assert property (@(posedge clock) disable iff (reset)
		dvalid && dready |=> !dvalid)
		else begin
			$error("dvalid still high after the accepting edge");
			fail_count++;
		end

	// Word access only
	full_strobe: assert property (@(posedge clock) disable iff (reset)
		dvalid |-> dwstb == 4'b1111)
		else begin
			$error("dwstb not all ones during a data bus request");
			fail_count++;
		end

endmodule

bind fw_core fw_core_asserts u_fw_core_asserts (
	.clock  (clock),
	.reset  (reset),
	.iaddr  (iaddr),
	.ivalid (ivalid),
	.iready (iready),
	.dvalid (dvalid),
	.daddr  (daddr),
	.dwdata (dwdata),
	.dwstb  (dwstb),
	.dwrite (dwrite),
	.dready (dready)
);

/* dv/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clock
);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;  // 100 ns period
	end

endmodule

/* dv/tb_iss_model.svh */
word_t model_pc;       // Model PC stepped once per accepted fetch
word_t model_regs [32];
word_t model_dmem [256];
word_t exp_addr [$];   // Data accesses in program order
word_t exp_data [$];
logic  exp_store [$];

task automatic reset_model();
	model_pc = '0;
	for (int i = 0; i < 32; i++) begin
		model_regs[i] = '0;
	end
endtask

task automatic step_model(input word_t ins);
	logic [6:0] opc;
	logic [2:0] f3;
	logic [6:0] f7;
	reg_idx_t   rd;
	word_t      a;
	word_t      b;
	word_t      addr;
	word_t      next;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_j;
	opc   = ins[6:0];
	f3    = ins[14:12];
	f7    = ins[31:25];
	rd    = ins[11:7];
	a     = model_regs[ins[19:15]];
	b     = model_regs[ins[24:20]];
	imm_i = {{20{ins[31]}}, ins[31:20]};
	imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
	imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
	imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
	next  = model_pc + 32'd4;
	case (opc)
		OPC_OP: begin
			case ({f7, f3})
				10'b0000000_000: model_regs[rd] = a + b;
				10'b0100000_000: model_regs[rd] = a - b;
				10'b0000000_111: model_regs[rd] = a & b;
				10'b0000000_110: model_regs[rd] = a | b;
				10'b0000000_100: model_regs[rd] = a ^ b;
				default: ;                                // Other R-type ops retire as no-ops
			endcase
		end
		OPC_OP_IMM: if (f3 == 3'b000) model_regs[rd] = a + imm_i;
		OPC_LUI: model_regs[rd] = {ins[31:12], 12'b0};
		OPC_LOAD: begin
			if (f3 == 3'b010) begin
				addr = a + imm_i;
				model_regs[rd] = model_dmem[addr[9:2]];
				exp_addr.push_back(addr);
				exp_data.push_back(model_dmem[addr[9:2]]);
				exp_store.push_back(1'b0);
			end
		end
		OPC_STORE: begin
			if (f3 == 3'b010) begin
				addr = a + imm_s;
				model_dmem[addr[9:2]] = b;
				exp_addr.push_back(addr);
				exp_data.push_back(b);
				exp_store.push_back(1'b1);
			end
		end
		OPC_BRANCH: begin
			if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) next = model_pc + imm_b;
		end
		OPC_JAL: begin
			model_regs[rd] = model_pc + 32'd4;
			next = model_pc + imm_j;
		end
		default: ;                                        // Unsupported encoding
	endcase
	model_regs[0] = '0;
	model_pc = next;
endtask

/* dv/tb_fw_core.sv */
`timescale 1ns/100ps

module tb_fw_core;
	import fw_core_pkg::*;

	localparam int    PROG_LEN   = 80;                 // Random instructions before the self-jump
	localparam int    MAX_CYCLES = 20000;
	localparam word_t FINAL_ADDR = word_t'(PROG_LEN * 4);

	logic       clock;
	logic       reset;
	word_t      iaddr;
	word_t      idata;
	logic       ivalid;
	logic       iready;
	logic       dvalid;
	word_t      daddr;
	word_t      dwdata;
	logic [3:0] dwstb;
	logic       dwrite;
	word_t      drdata;
	logic       dready;

	integer seed;
	word_t  imem [256];
	word_t  data_mem [256];
	logic   ipending;
	logic   dpending;
	int     idelay;
	int     ddelay;
	int     final_hits;

	`include "tb_iss_model.svh"

	tb_clock_gen u_clock_gen (.clock(clock));

	fw_core u_fw_core (
		.clock  (clock),
		.reset  (reset),
		.iaddr  (iaddr),
		.idata  (idata),
		.ivalid (ivalid),
		.iready (iready),
		.dvalid (dvalid),
		.daddr  (daddr),
		.dwdata (dwdata),
		.dwstb  (dwstb),
		.dwrite (dwrite),
		.drdata (drdata),
		.dready (dready)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "Simulation stopped after a failed check");
	endtask

	function automatic word_t r_type(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd, rs1, rs2);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic word_t i_type(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd, rs1,
		logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t s_type(reg_idx_t rs1, rs2, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
	endfunction

	function automatic word_t b_type(logic [2:0] f3, reg_idx_t rs1, rs2, logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic word_t j_type(reg_idx_t rd, logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	// Preload pattern distinct for every word address
	function automatic word_t fill_word(word_t addr);
		return (addr * 32'h0101_0193) ^ 32'hc0de_5a5a;
	endfunction

	task automatic build_program();
		word_t      r;
		int         kind;
		int         off;
		logic [6:0] opc;
		imem[0] = i_type(OPC_LOAD, 3'b010, 5'd1, 5'd0, 12'd12);  // Load then write back unchanged
		imem[1] = s_type(5'd0, 5'd1, 12'd44);
		for (int k = 2; k < PROG_LEN; k++) begin
			kind = $random(seed) & 32'd15;
			r    = $random(seed);
			off  = ($random(seed) & 32'd3) + 1;            // Forward distance in words
			if (off > PROG_LEN - k) off = PROG_LEN - k;
			case (kind)
				0, 1, 2: begin
					case (r[6:4])
						3'd1:    imem[k] = r_type(7'b0100000, 3'b000, {2'b00, r[9:7]},
							{2'b00, r[12:10]}, {2'b00, r[15:13]});
						3'd2:    imem[k] = r_type(7'b0000000, 3'b111, {2'b00, r[9:7]},
							{2'b00, r[12:10]}, {2'b00, r[15:13]});
						3'd3:    imem[k] = r_type(7'b0000000, 3'b110, {2'b00, r[9:7]},
							{2'b00, r[12:10]}, {2'b00, r[15:13]});
						3'd4:    imem[k] = r_type(7'b0000000, 3'b100, {2'b00, r[9:7]},
							{2'b00, r[12:10]}, {2'b00, r[15:13]});
						default: imem[k] = r_type(7'b0000000, 3'b000, {2'b00, r[9:7]},
							{2'b00, r[12:10]}, {2'b00, r[15:13]});
					endcase
				end
				5: imem[k] = {r[31:12], 2'b00, r[9:7], OPC_LUI};
				6, 7: imem[k] = i_type(OPC_LOAD, 3'b010, {2'b00, r[9:7]}, 5'd0,
					{6'd0, r[19:16], 2'b00});
				8, 9, 10: imem[k] = s_type(5'd0, {2'b00, r[15:13]}, {6'd0, r[19:16], 2'b00});
				11, 12: imem[k] = b_type({2'b00, r[16]}, {2'b00, r[12:10]}, {2'b00, r[15:13]},
					13'(off * 4));
				13: imem[k] = j_type({2'b00, r[9:7]}, 21'(off * 4));
				14: begin
					case (r[1:0])
						2'd0: opc = 7'b0001111;                  // FENCE
						2'd1: opc = 7'b1110011;                  // SYSTEM
						2'd2: opc = 7'b0010111;                  // AUIPC
						default: opc = 7'b1100111;               // JALR
					endcase
					imem[k] = {r[31:7], opc};
				end
				default: imem[k] = i_type(OPC_OP_IMM, 3'b000, {2'b00, r[9:7]},
					{2'b00, r[12:10]}, r[27:16]);
			endcase
		end
		imem[PROG_LEN] = j_type(5'd0, 21'd0);              // Self-jump ends the run
	endtask

	task automatic serve_ibus();
		if (iready) begin
			iready = 1'b0;                                   // Taken at the last rising edge
		end else if (ivalid) begin
			if (!ipending) begin
				ipending = 1'b1;
				idelay   = $random(seed) & 32'd3;
			end
			if (idelay == 0) begin
				assert (iaddr == model_pc) else
					report_failure($sformatf("MISMATCH at %0t: fetch address %h, expected %h",
						$time, iaddr, model_pc));
				if (iaddr == FINAL_ADDR) final_hits++;
				idata    = imem[iaddr[9:2]];
				iready   = 1'b1;
				ipending = 1'b0;
				step_model(idata);
			end else begin
				idelay--;
			end
		end
	endtask

	task automatic serve_dbus();
		if (dready) begin
			dready = 1'b0;
		end else if (dvalid) begin
			if (!dpending) begin
				dpending = 1'b1;
				ddelay   = $random(seed) & 32'd3;
			end
			if (ddelay == 0) begin
				assert (exp_addr.size() > 0) else
					report_failure("Unexpected data access from the core");
				assert (dwstb == 4'b1111) else
					report_failure($sformatf("MISMATCH at %0t: dwstb %b, expected 1111",
						$time, dwstb));
				assert (dwrite == exp_store[0] && daddr == exp_addr[0]) else
					report_failure($sformatf(
						"MISMATCH at %0t: access %h write %b, expected %h write %b",
						$time, daddr, dwrite, exp_addr[0], exp_store[0]));
				if (dwrite) begin
					assert (dwdata == exp_data[0]) else
						report_failure($sformatf(
							"MISMATCH at %0t: store data %h at %h, expected %h",
							$time, dwdata, daddr, exp_data[0]));
					data_mem[daddr[9:2]] = dwdata;
				end
				drdata = data_mem[daddr[9:2]];
				dready = 1'b1;
				dpending = 1'b0;
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
				void'(exp_store.pop_front());
			end else begin
				ddelay--;
			end
		end
	endtask

	initial begin
		int cycles;
		seed       = 82;
		reset      = 1'b1;
		idata      = '0;
		iready     = 1'b0;
		drdata     = '0;
		dready     = 1'b0;
		ipending   = 1'b0;
		dpending   = 1'b0;
		idelay     = 0;
		ddelay     = 0;
		final_hits = 0;
		build_program();
		for (int i = 0; i < 256; i++) begin
			data_mem[i]   = fill_word(word_t'(i * 4));
			model_dmem[i] = fill_word(word_t'(i * 4));
		end
		reset_model();
		repeat (4) begin
			@(negedge clock);
			assert (!ivalid && !dvalid) else
				report_failure("A bus request was raised while reset was held");
		end
		reset  = 1'b0;
		cycles = 0;
		while (final_hits < 2 && cycles < MAX_CYCLES) begin
			@(negedge clock);
			serve_ibus();
			serve_dbus();
			cycles++;
		end
		if (final_hits < 2) begin
			report_failure("Timeout: the core never reached the final self-jump");
		end else begin
			assert (exp_addr.size() == 0) else
				report_failure("Loads or stores of the program never appeared on the data bus");
			assert (u_fw_core.u_fw_core_asserts.fail_count == 0) else
				report_failure("A bus protocol assertion failed during the run");
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

/* fw_core.f */
+incdir+dv
logic/fw_core_pkg.sv
logic/fw_core_ifs.sv
logic/fw_fetch.sv
logic/fw_decode.sv
logic/fw_exec.sv
logic/fw_regfile.sv
logic/fw_core.sv
dv/tb_clock_gen.sv
dv/fw_core_asserts.sv
dv/tb_fw_core.sv

/* logic/fw_core.sv */
`timescale 1ns/100ps

module fw_core (
	input  logic               clock,
	input  logic               reset,

	output fw_core_pkg::word_t iaddr,
	input  fw_core_pkg::word_t idata,
	output logic               ivalid,
	input  logic               iready,

	output logic               dvalid,
	output fw_core_pkg::word_t daddr,
	output fw_core_pkg::word_t dwdata,
	output logic [3:0]         dwstb,
	output logic               dwrite,
	input  fw_core_pkg::word_t drdata,
	input  logic               dready
);
	import fw_core_pkg::*;

	logic     fetch_valid;
	word_t    instr;
	logic     instr_complete;
	word_t    next_pc;
	logic     next_pc_seq;
	reg_idx_t rd_waddr;
	word_t    rd_wdata;
	logic     rd_wen;

	regfile_read_if rf_bus ();
	decode_exec_if  dx_bus ();

	fw_fetch u_fetch (
		.clock          (clock),
		.reset          (reset),
		.next_pc        (next_pc),
		.next_pc_seq    (next_pc_seq),
		.instr_complete (instr_complete),
		.iaddr          (iaddr),
		.idata          (idata),
		.ivalid         (ivalid),
		.iready         (iready),
		.fetch_valid    (fetch_valid),
		.instr          (instr)
	);

	// Fetch holds the PC steady while decode works on it
	fw_decode u_decode (
		.clock       (clock),
		.reset       (reset),
		.fetch_valid (fetch_valid),
		.instr       (instr),
		.pc          (iaddr),
		.rf          (rf_bus.decode),
		.dx          (dx_bus.decode)
	);

	fw_exec u_exec (
		.clock          (clock),
		.reset          (reset),
		.dx             (dx_bus.exec),
		.rd_waddr       (rd_waddr),
		.rd_wdata       (rd_wdata),
		.rd_wen         (rd_wen),
		.instr_complete (instr_complete),
		.next_pc        (next_pc),
		.next_pc_seq    (next_pc_seq),
		.dvalid         (dvalid),
		.daddr          (daddr),
		.dwdata         (dwdata),
		.dwstb          (dwstb),
		.dwrite         (dwrite),
		.drdata         (drdata),
		.dready         (dready)
	);

	fw_regfile u_regfile (
		.clock    (clock),
		.reset    (reset),
		.rf       (rf_bus.regfile),
		.rd_waddr (rd_waddr),
		.rd_wdata (rd_wdata),
		.rd_wen   (rd_wen)
	);

endmodule

/* logic/fw_core_ifs.sv */
`timescale 1ns/100ps

// Two read ports into the register file with data returned combinationally
interface regfile_read_if;
	import fw_core_pkg::*;

	reg_idx_t ra_raddr;
	word_t    ra_rdata;
	reg_idx_t rb_raddr;
	word_t    rb_rdata;

	modport decode (
		output ra_raddr,
		output rb_raddr,
		input  ra_rdata,
		input  rb_rdata
	);

	modport regfile (
		input  ra_raddr,
		input  rb_raddr,
		output ra_rdata,
		output rb_rdata
	);

endinterface

// Decoded operation handed from decode to exec
interface decode_exec_if;
	import fw_core_pkg::*;

	logic     decode_valid;  // One-cycle pulse
	exec_op_e op;
	word_t    op_a;
	word_t    op_b;
	word_t    op_c;          // Store data or branch/jump offset
	reg_idx_t rd;
	word_t    pc;

	modport decode (
		output decode_valid,
		output op,
		output op_a,
		output op_b,
		output op_c,
		output rd,
		output pc
	);

	modport exec (
		input decode_valid,
		input op,
		input op_a,
		input op_b,
		input op_c,
		input rd,
		input pc
	);

endinterface

/* logic/fw_core_pkg.sv */
package fw_core_pkg;

	typedef logic [31:0] word_t;     // Data, address or instruction
	typedef logic [4:0]  reg_idx_t;  // Register number

	// RV32I major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		OP_LOAD,
		OP_STORE,
		OP_BEQ,
		OP_BNE,
		OP_JAL,
		OP_NOP
	} exec_op_e;

	typedef enum logic [1:0] {
		FETCH_REQ,
		FETCH_WAIT_DECODE,
		FETCH_WAIT_EXEC
	} fetch_state_e;

	typedef enum logic {
		EXEC_IDLE,
		EXEC_MEM
	} exec_state_e;

endpackage

/* logic/fw_decode.sv */
`timescale 1ns/100ps

module fw_decode (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   fetch_valid,
	input  fw_core_pkg::word_t     instr,
	input  fw_core_pkg::word_t     pc,
	regfile_read_if.decode         rf,
	decode_exec_if.decode          dx
);
	import fw_core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t   rs1;
	reg_idx_t   rs2;
	reg_idx_t   rd;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;
	exec_op_e   op_nx;
	word_t      op_a_nx;
	word_t      op_b_nx;
	word_t      op_c_nx;
	reg_idx_t   rd_nx;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign rd     = instr[11:7];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign rf.ra_raddr = rs1;
	assign rf.rb_raddr = rs2;

	always_comb begin
		op_nx   = OP_NOP;
		op_a_nx = rf.ra_rdata;
		op_b_nx = rf.rb_rdata;
		op_c_nx = '0;
		rd_nx   = '0;                                 // No write unless set below
		case (opcode)
			OPC_OP: begin
				rd_nx = rd;
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000:  op_nx = ALU_ADD;
						3'b100:  op_nx = ALU_XOR;
						3'b110:  op_nx = ALU_OR;
						3'b111:  op_nx = ALU_AND;
						default: op_nx = OP_NOP;
					endcase
				end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					op_nx = ALU_SUB;
				end
			end
			OPC_OP_IMM: begin
				if (funct3 == 3'b000) begin
					op_nx   = ALU_ADD;                  // ADDI
					op_b_nx = imm_i;
					rd_nx   = rd;
				end
			end
			OPC_LUI: begin
				op_nx   = ALU_ADD;
				op_a_nx = '0;
				op_b_nx = imm_u;
				rd_nx   = rd;
			end
			OPC_LOAD: begin
				if (funct3 == 3'b010) begin
					op_nx   = OP_LOAD;
					op_b_nx = imm_i;
					rd_nx   = rd;
				end
			end
			OPC_STORE: begin
				if (funct3 == 3'b010) begin
					op_nx   = OP_STORE;
					op_b_nx = imm_s;
					op_c_nx = rf.rb_rdata;              // Store data
				end
			end
			OPC_BRANCH: begin
				op_c_nx = imm_b;
				case (funct3)
					3'b000:  op_nx = OP_BEQ;
					3'b001:  op_nx = OP_BNE;
					default: op_nx = OP_NOP;
				endcase
			end
			OPC_JAL: begin
				op_nx   = OP_JAL;
				op_a_nx = pc;
				op_b_nx = 32'd4;                        // ALU sum gives link address
				op_c_nx = imm_j;
				rd_nx   = rd;
			end
			default: op_nx = OP_NOP;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			dx.decode_valid <= 1'b0;
		end else begin
			dx.decode_valid <= fetch_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_valid) begin
			dx.op   <= op_nx;
			dx.op_a <= op_a_nx;
			dx.op_b <= op_b_nx;
			dx.op_c <= op_c_nx;
			dx.rd   <= rd_nx;
			dx.pc   <= pc;
		end
	end

endmodule

/* logic/fw_exec.sv */
`timescale 1ns/100ps

module fw_exec (
	input  logic                  clock,
	input  logic                  reset,
	decode_exec_if.exec           dx,
	output fw_core_pkg::reg_idx_t rd_waddr,
	output fw_core_pkg::word_t    rd_wdata,
	output logic                  rd_wen,
	output logic                  instr_complete,
	output fw_core_pkg::word_t    next_pc,
	output logic                  next_pc_seq,
	output logic                  dvalid,
	output fw_core_pkg::word_t    daddr,
	output fw_core_pkg::word_t    dwdata,
	output logic [3:0]            dwstb,
	output logic                  dwrite,
	input  fw_core_pkg::word_t    drdata,
	input  logic                  dready
);
	import fw_core_pkg::*;

	exec_state_e state;
	word_t       alu_result;
	logic        operands_eq;
	logic        taken;
	logic        is_mem;
	logic        writes_rd;
	logic        start;
	logic        mem_done;

	assign dwstb = 4'b1111;                           // Word access only

	assign start    = (state == EXEC_IDLE) && dx.decode_valid;
	assign mem_done = (state == EXEC_MEM) && dready;

	always_comb begin
		case (dx.op)
			ALU_SUB: alu_result = dx.op_a - dx.op_b;
			ALU_AND: alu_result = dx.op_a & dx.op_b;
			ALU_OR:  alu_result = dx.op_a | dx.op_b;
			ALU_XOR: alu_result = dx.op_a ^ dx.op_b;
			default: alu_result = dx.op_a + dx.op_b;  // ADD, LUI, JAL link
		endcase
	end

	assign operands_eq = (dx.op_a == dx.op_b);
	assign taken = (dx.op == OP_JAL) ||
		(dx.op == OP_BEQ && operands_eq) ||
		(dx.op == OP_BNE && !operands_eq);
	assign is_mem = (dx.op == OP_LOAD) || (dx.op == OP_STORE);
	assign writes_rd = (dx.op == ALU_ADD) || (dx.op == ALU_SUB) || (dx.op == ALU_AND) ||
		(dx.op == ALU_OR) || (dx.op == ALU_XOR) || (dx.op == OP_JAL);

	always_ff @(posedge clock) begin
		if (reset) begin
			state          <= EXEC_IDLE;
			instr_complete <= 1'b0;
			rd_wen         <= 1'b0;
			next_pc_seq    <= 1'b1;
			dvalid         <= 1'b0;
			dwrite         <= 1'b0;
		end else begin
			instr_complete <= 1'b0;
			rd_wen         <= 1'b0;
			case (state)
				EXEC_IDLE: begin
					if (dx.decode_valid) begin
						if (is_mem) begin
							dvalid <= 1'b1;
							dwrite <= (dx.op == OP_STORE);
							state  <= EXEC_MEM;
						end else begin
							instr_complete <= 1'b1;
							rd_wen         <= writes_rd;
							next_pc_seq    <= !taken;
						end
					end
				end
				EXEC_MEM: begin
					if (dready) begin
						dvalid         <= 1'b0;
						dwrite         <= 1'b0;
						instr_complete <= 1'b1;
						rd_wen         <= !dwrite;  // Load result goes back
						next_pc_seq    <= 1'b1;
						state          <= EXEC_IDLE;
					end
				end
				default: state <= EXEC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			rd_waddr <= dx.rd;
			rd_wdata <= alu_result;
			next_pc  <= dx.pc + dx.op_c;              // Branch or jump target
			daddr    <= dx.op_a + dx.op_b;
			dwdata   <= dx.op_c;
		end else if (mem_done) begin
			rd_wdata <= drdata;
		end
	end

endmodule

/* logic/fw_fetch.sv */
`timescale 1ns/100ps

module fw_fetch (
	input  logic               clock,
	input  logic               reset,
	input  fw_core_pkg::word_t next_pc,
	input  logic               next_pc_seq,
	input  logic               instr_complete,
	output fw_core_pkg::word_t iaddr,
	input  fw_core_pkg::word_t idata,
	output logic               ivalid,
	input  logic               iready,
	output logic               fetch_valid,
	output fw_core_pkg::word_t instr
);
	import fw_core_pkg::*;

	fetch_state_e state;
	word_t        pc;
	logic         accept;

	assign iaddr  = pc;
	assign accept = (state == FETCH_REQ) && ivalid && iready;

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= FETCH_REQ;
			pc          <= '0;
			ivalid      <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= 1'b0;
			case (state)
				FETCH_REQ: begin
					if (!ivalid) begin
						ivalid <= 1'b1;              // First request out of reset
					end else if (iready) begin
						ivalid      <= 1'b0;
						fetch_valid <= 1'b1;
						state       <= FETCH_WAIT_DECODE;
					end
				end
				FETCH_WAIT_DECODE: begin
					state <= FETCH_WAIT_EXEC;        // Decode busy this cycle
				end
				FETCH_WAIT_EXEC: begin
					if (instr_complete) begin
						pc     <= next_pc_seq ? pc + 32'd4 : next_pc;
						ivalid <= 1'b1;
						state  <= FETCH_REQ;
					end
				end
				default: state <= FETCH_REQ;
			endcase
		end
	end

	// Instruction word held until the next fetch is accepted
	always_ff @(posedge clock) begin
		if (accept) begin
			instr <= idata;
		end
	end

endmodule

/* logic/fw_regfile.sv */
`timescale 1ns/100ps

module fw_regfile (
	input  logic                  clock,
	input  logic                  reset,
	regfile_read_if.regfile       rf,
	input  fw_core_pkg::reg_idx_t rd_waddr,
	input  fw_core_pkg::word_t    rd_wdata,
	input  logic                  rd_wen
);
	import fw_core_pkg::*;

	word_t regs [32];

	// Asynchronous reads with x0 kept at zero by the write guard
	assign rf.ra_rdata = regs[rf.ra_raddr];
	assign rf.rb_rdata = regs[rf.rb_raddr];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_wen && rd_waddr != '0) begin
			regs[rd_waddr] <= rd_wdata;
		end
	end

endmodule
